//--- src/mmu_params.svh
`ifndef MMU_PARAMS_SVH
`define MMU_PARAMS_SVH

// number of TLB entries, each one maps an even/odd page pair
`define MMU_TLB_ENTRIES 16

// width of a TLB index, ceiling of log2 of the entry count
`define MMU_IDX_W $clog2(`MMU_TLB_ENTRIES)

// address space identifier width, as in entryhi
`define MMU_ASID_W 8

`endif

//--- src/mmu_pkg.sv
`default_nettype none

`include "mmu_params.svh"

package mmu_pkg;

    localparam int VPN2_W = 19;
    localparam int PFN_W  = 20;

    // one TLB entry, a pair of 4 KiB pages
    typedef struct packed {
        logic [VPN2_W-1:0]      vpn2;
        logic [`MMU_ASID_W-1:0] asid;
        logic                   g;
        logic [PFN_W-1:0]       pfn0;
        logic [PFN_W-1:0]       pfn1;
        logic [2:0]             c0;
        logic [2:0]             c1;
        logic                   d0;
        logic                   d1;
        logic                   v0;
        logic                   v1;
    } tlb_entry_t;

    // host command opcodes
    typedef enum logic [2:0] {
        CMD_WREG  = 3'd0,
        CMD_RREG  = 3'd1,
        CMD_TLBWI = 3'd2,
        CMD_TLBR  = 3'd3,
        CMD_TLBP  = 3'd4
    } cmd_op_e;

    // register select for CMD_WREG and CMD_RREG
    typedef enum logic [2:0] {
        SEL_INDEX  = 3'd0,
        SEL_LO0    = 3'd1,
        SEL_LO1    = 3'd2,
        SEL_HI     = 3'd3,
        SEL_CONFIG = 3'd4
    } reg_sel_e;

    // entrylo word layout
    localparam int ELO_PFN_HI = 25;
    localparam int ELO_PFN_LO = 6;
    localparam int ELO_C_HI   = 5;
    localparam int ELO_C_LO   = 3;
    localparam int ELO_D      = 2;
    localparam int ELO_V      = 1;
    localparam int ELO_G      = 0;

    // entryhi word layout
    localparam int EHI_VPN2_HI = 31;
    localparam int EHI_VPN2_LO = 13;
    localparam int EHI_ASID_HI = `MMU_ASID_W - 1;
    localparam int EHI_ASID_LO = 0;

    // index and config layouts
    localparam int IDX_P     = 31;
    localparam int CFG_K0_UC = 0;

endpackage

`default_nettype wire

//--- src/seg_mapper.sv
`timescale 1ns/1ps
`default_nettype none

module seg_mapper (
    input  wire logic [31:0] i_vaddr,
    input  wire logic        i_k0_uncached,
    output logic             o_mapped,
    output logic [31:0]      o_paddr,
    output logic             o_uncached
);

    logic is_kseg0;
    logic is_kseg1;

    // kuseg is 0xxx, kseg2/kseg3 are 11xx, both go through the TLB
    assign o_mapped = ~i_vaddr[31] | (i_vaddr[31:30] == 2'b11);

    assign is_kseg0 = (i_vaddr[31:29] == 3'b100);
    assign is_kseg1 = (i_vaddr[31:29] == 3'b101);

    // kseg0 and kseg1 both alias the low 512 MiB
    assign o_paddr = {3'b000, i_vaddr[28:0]};

    // kseg1 is never cached, kseg0 follows the config bit
    assign o_uncached = is_kseg1 | (is_kseg0 & i_k0_uncached);

endmodule

`default_nettype wire

//--- src/tlb_match.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmu_params.svh"

module tlb_match import mmu_pkg::*; (
    input  wire tlb_entry_t [`MMU_TLB_ENTRIES-1:0] i_table,
    input  wire logic [31:0]                       i_vaddr,
    input  wire logic [`MMU_ASID_W-1:0]            i_asid,
    output logic                                   o_hit,
    output logic [`MMU_IDX_W-1:0]                  o_index,
    output logic [PFN_W-1:0]                       o_pfn,
    output logic [2:0]                             o_cattr,
    output logic                                   o_valid,
    output logic                                   o_dirty
);

    localparam int ENTRIES = `MMU_TLB_ENTRIES;
    localparam int IDX_W   = `MMU_IDX_W;

    logic [ENTRIES-1:0] hit_mask;
    logic [IDX_W-1:0]   hit_idx;
    tlb_entry_t         sel;
    logic               odd;

    for (genvar i = 0; i < ENTRIES; i++) begin : g_cmp
        assign hit_mask[i] = (i_table[i].vpn2 == i_vaddr[31:13]) &&
                             ((i_table[i].asid == i_asid) || i_table[i].g);
    end

    // walk down so the lowest matching entry is left in hit_idx
    always_comb begin
        hit_idx = '0;
        for (int i = ENTRIES - 1; i >= 0; i--) begin
            if (hit_mask[i]) begin
                hit_idx = IDX_W'(i);
            end
        end
    end

    assign sel  = i_table[hit_idx];
    assign odd  = i_vaddr[12];

    assign o_hit   = |hit_mask;
    assign o_index = hit_idx;

    // bit 12 picks the odd page of the pair
    assign o_pfn   = odd ? sel.pfn1 : sel.pfn0;
    assign o_cattr = odd ? sel.c1   : sel.c0;
    assign o_valid = odd ? sel.v1   : sel.v0;
    assign o_dirty = odd ? sel.d1   : sel.d0;

endmodule

`default_nettype wire

//--- src/tlb_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmu_params.svh"

module tlb_array import mmu_pkg::*; (
    input  wire logic                               clk,
    input  wire logic                               resetn,
    input  wire logic                               i_we,
    input  wire logic [`MMU_IDX_W-1:0]              i_widx,
    input  wire tlb_entry_t                         i_wentry,
    input  wire logic [`MMU_IDX_W-1:0]              i_ridx,
    output tlb_entry_t                              o_rentry,
    output tlb_entry_t [`MMU_TLB_ENTRIES-1:0]       o_table
);

    localparam int ENTRIES = `MMU_TLB_ENTRIES;

    tlb_entry_t [ENTRIES-1:0] table_q;

    // every entry starts out zero so lookups after reset are defined
    always_ff @(posedge clk) begin
        if (!resetn) begin
            table_q <= '0;
        end else if (i_we) begin
            table_q[i_widx] <= i_wentry;
        end
    end

    // indexed read for TLBR
    assign o_rentry = table_q[i_ridx];

    // whole table fans out to the match units
    assign o_table = table_q;

endmodule

`default_nettype wire

//--- src/tlb_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmu_params.svh"

module tlb_regs import mmu_pkg::*; (
    input  wire logic                     clk,
    input  wire logic                     resetn,
    input  wire logic                     i_cmd_req,
    input  wire cmd_op_e                  i_cmd_op,
    input  wire reg_sel_e                 i_cmd_sel,
    input  wire logic [31:0]              i_cmd_wdata,
    output logic                          o_cmd_ack,
    output logic [31:0]                   o_cmd_rdata,
    output logic [`MMU_ASID_W-1:0]        o_asid,
    output logic                          o_k0_uncached,
    output logic                          o_we,
    output logic [`MMU_IDX_W-1:0]         o_widx,
    output tlb_entry_t                    o_wentry,
    output logic [`MMU_IDX_W-1:0]         o_ridx,
    input  wire tlb_entry_t               i_rentry,
    output logic [31:0]                   o_probe_vaddr,
    input  wire logic                     i_probe_hit,
    input  wire logic [`MMU_IDX_W-1:0]    i_probe_index
);

    localparam int IDX_W = `MMU_IDX_W;

    // writable bits of each register
    localparam logic [31:0] LO_MASK  = (32'h1 << (ELO_PFN_HI + 1)) - 32'h1;
    localparam logic [31:0] HI_MASK  = ~((32'h1 << EHI_VPN2_LO) - 32'h1) |
                                       ((32'h1 << (EHI_ASID_HI + 1)) - 32'h1);
    localparam logic [31:0] IDX_MASK = (32'h1 << IDX_P) | ((32'h1 << IDX_W) - 32'h1);
    localparam logic [31:0] CFG_MASK = 32'h1 << CFG_K0_UC;

    logic [31:0] index_q;
    logic [31:0] lo0_q;
    logic [31:0] lo1_q;
    logic [31:0] hi_q;
    logic [31:0] cfg_q;
    logic        ack_q;
    logic [31:0] rdata_q;
    logic [31:0] sel_rdata;
    logic        cmd_fire;

    function automatic logic [31:0] pack_lo(input logic [PFN_W-1:0] pfn,
                                            input logic [2:0] c,
                                            input logic d,
                                            input logic v,
                                            input logic g);
        logic [31:0] w;
        w = '0;
        w[ELO_PFN_HI:ELO_PFN_LO] = pfn;
        w[ELO_C_HI:ELO_C_LO]     = c;
        w[ELO_D]                 = d;
        w[ELO_V]                 = v;
        w[ELO_G]                 = g;
        return w;
    endfunction

    // a command is taken on the edge where req is seen high and ack is still low
    assign cmd_fire = i_cmd_req & ~ack_q;

    always_comb begin
        case (i_cmd_sel)
            SEL_INDEX:  sel_rdata = index_q;
            SEL_LO0:    sel_rdata = lo0_q;
            SEL_LO1:    sel_rdata = lo1_q;
            SEL_HI:     sel_rdata = hi_q;
            SEL_CONFIG: sel_rdata = cfg_q;
            default:    sel_rdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ack_q   <= 1'b0;
            index_q <= '0;
            lo0_q   <= '0;
            lo1_q   <= '0;
            hi_q    <= '0;
            cfg_q   <= '0;
        end else if (cmd_fire) begin
            ack_q <= 1'b1;
            case (i_cmd_op)
                CMD_WREG: begin
                    case (i_cmd_sel)
                        SEL_INDEX:  index_q <= i_cmd_wdata & IDX_MASK;
                        SEL_LO0:    lo0_q   <= i_cmd_wdata & LO_MASK;
                        SEL_LO1:    lo1_q   <= i_cmd_wdata & LO_MASK;
                        SEL_HI:     hi_q    <= i_cmd_wdata & HI_MASK;
                        SEL_CONFIG: cfg_q   <= i_cmd_wdata & CFG_MASK;
                        default: ;
                    endcase
                end
                CMD_TLBR: begin
                    hi_q <= '0;
                    hi_q[EHI_VPN2_HI:EHI_VPN2_LO] <= i_rentry.vpn2;
                    hi_q[EHI_ASID_HI:EHI_ASID_LO] <= i_rentry.asid;
                    // the single stored G shows up in both halves
                    lo0_q <= pack_lo(i_rentry.pfn0, i_rentry.c0, i_rentry.d0,
                                     i_rentry.v0, i_rentry.g);
                    lo1_q <= pack_lo(i_rentry.pfn1, i_rentry.c1, i_rentry.d1,
                                     i_rentry.v1, i_rentry.g);
                end
                CMD_TLBP: begin
                    index_q <= '0;
                    index_q[IDX_P] <= ~i_probe_hit;
                    index_q[IDX_W-1:0] <= i_probe_hit ? i_probe_index : '0;
                end
                default: ;
            endcase
        end else if (ack_q && !i_cmd_req) begin
            ack_q <= 1'b0;
        end
    end

    // read data is held for as long as ack stays up
    always_ff @(posedge clk) begin
        if (cmd_fire) begin
            rdata_q <= (i_cmd_op == CMD_RREG) ? sel_rdata : '0;
        end
    end

    assign o_cmd_ack   = ack_q;
    assign o_cmd_rdata = rdata_q;

    // TLBWI writes on the same edge that raises ack
    assign o_we   = cmd_fire & (i_cmd_op == CMD_TLBWI);
    assign o_widx = index_q[IDX_W-1:0];
    assign o_ridx = index_q[IDX_W-1:0];

    always_comb begin
        o_wentry      = '0;
        o_wentry.vpn2 = hi_q[EHI_VPN2_HI:EHI_VPN2_LO];
        o_wentry.asid = hi_q[EHI_ASID_HI:EHI_ASID_LO];
        o_wentry.g    = lo0_q[ELO_G] & lo1_q[ELO_G];
        o_wentry.pfn0 = lo0_q[ELO_PFN_HI:ELO_PFN_LO];
        o_wentry.pfn1 = lo1_q[ELO_PFN_HI:ELO_PFN_LO];
        o_wentry.c0   = lo0_q[ELO_C_HI:ELO_C_LO];
        o_wentry.c1   = lo1_q[ELO_C_HI:ELO_C_LO];
        o_wentry.d0   = lo0_q[ELO_D];
        o_wentry.d1   = lo1_q[ELO_D];
        o_wentry.v0   = lo0_q[ELO_V];
        o_wentry.v1   = lo1_q[ELO_V];
    end

    assign o_asid        = hi_q[EHI_ASID_HI:EHI_ASID_LO];
    assign o_k0_uncached = cfg_q[CFG_K0_UC];
    assign o_probe_vaddr = hi_q;

endmodule

`default_nettype wire

//--- src/translation_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmu_params.svh"

module translation_unit import mmu_pkg::*; (
    input  wire logic        clk,
    input  wire logic        resetn,

    // host command port
    input  wire logic        i_cmd_req,
    input  wire cmd_op_e     i_cmd_op,
    input  wire reg_sel_e    i_cmd_sel,
    input  wire logic [31:0] i_cmd_wdata,
    output logic             o_cmd_ack,
    output logic [31:0]      o_cmd_rdata,

    // instruction lookup
    input  wire logic [31:0] i_iaddr,
    output logic [31:0]      o_ipaddr,
    output logic             o_iuncached,
    output logic             o_irefill,
    output logic             o_iinvalid,
    output logic             o_imodified,

    // data lookup
    input  wire logic [31:0] i_daddr,
    output logic [31:0]      o_dpaddr,
    output logic             o_duncached,
    output logic             o_drefill,
    output logic             o_dinvalid,
    output logic             o_dmodified
);

    logic [`MMU_ASID_W-1:0]              asid;
    logic                                k0_uncached;
    logic                                tlb_we;
    logic [`MMU_IDX_W-1:0]               tlb_widx;
    tlb_entry_t                          tlb_wentry;
    logic [`MMU_IDX_W-1:0]               tlb_ridx;
    tlb_entry_t                          tlb_rentry;
    tlb_entry_t [`MMU_TLB_ENTRIES-1:0]   tlb_table;
    logic [31:0]                         probe_vaddr;
    logic                                probe_hit;
    logic [`MMU_IDX_W-1:0]               probe_index;

    logic             inst_hit;
    logic [PFN_W-1:0] inst_pfn;
    logic [2:0]       inst_cattr;
    logic             inst_valid;
    logic             inst_dirty;
    logic             inst_mapped;
    logic [31:0]      inst_direct;
    logic             inst_seg_uc;

    logic             data_hit;
    logic [PFN_W-1:0] data_pfn;
    logic [2:0]       data_cattr;
    logic             data_valid;
    logic             data_dirty;
    logic             data_mapped;
    logic [31:0]      data_direct;
    logic             data_seg_uc;

    tlb_regs u_regs (
        .clk           (clk),
        .resetn        (resetn),
        .i_cmd_req     (i_cmd_req),
        .i_cmd_op      (i_cmd_op),
        .i_cmd_sel     (i_cmd_sel),
        .i_cmd_wdata   (i_cmd_wdata),
        .o_cmd_ack     (o_cmd_ack),
        .o_cmd_rdata   (o_cmd_rdata),
        .o_asid        (asid),
        .o_k0_uncached (k0_uncached),
        .o_we          (tlb_we),
        .o_widx        (tlb_widx),
        .o_wentry      (tlb_wentry),
        .o_ridx        (tlb_ridx),
        .i_rentry      (tlb_rentry),
        .o_probe_vaddr (probe_vaddr),
        .i_probe_hit   (probe_hit),
        .i_probe_index (probe_index)
    );

    tlb_array u_array (
        .clk      (clk),
        .resetn   (resetn),
        .i_we     (tlb_we),
        .i_widx   (tlb_widx),
        .i_wentry (tlb_wentry),
        .i_ridx   (tlb_ridx),
        .o_rentry (tlb_rentry),
        .o_table  (tlb_table)
    );

    tlb_match imatch (
        .i_table (tlb_table),
        .i_vaddr (i_iaddr),
        .i_asid  (asid),
        .o_hit   (inst_hit),
        .o_index (),
        .o_pfn   (inst_pfn),
        .o_cattr (inst_cattr),
        .o_valid (inst_valid),
        .o_dirty (inst_dirty)
    );

    tlb_match dmatch (
        .i_table (tlb_table),
        .i_vaddr (i_daddr),
        .i_asid  (asid),
        .o_hit   (data_hit),
        .o_index (),
        .o_pfn   (data_pfn),
        .o_cattr (data_cattr),
        .o_valid (data_valid),
        .o_dirty (data_dirty)
    );

    // probe only needs hit and index, page attributes are not used
    tlb_match pmatch (
        .i_table (tlb_table),
        .i_vaddr (probe_vaddr),
        .i_asid  (asid),
        .o_hit   (probe_hit),
        .o_index (probe_index),
        .o_pfn   (),
        .o_cattr (),
        .o_valid (),
        .o_dirty ()
    );

    seg_mapper u_iseg (
        .i_vaddr       (i_iaddr),
        .i_k0_uncached (k0_uncached),
        .o_mapped      (inst_mapped),
        .o_paddr       (inst_direct),
        .o_uncached    (inst_seg_uc)
    );

    seg_mapper u_dseg (
        .i_vaddr       (i_daddr),
        .i_k0_uncached (k0_uncached),
        .o_mapped      (data_mapped),
        .o_paddr       (data_direct),
        .o_uncached    (data_seg_uc)
    );

    // instruction port results
    assign o_ipaddr    = inst_mapped ? {inst_pfn, i_iaddr[11:0]} : inst_direct;
    assign o_iuncached = inst_mapped ? (inst_hit & (inst_cattr != 3'd3)) : inst_seg_uc;
    assign o_irefill   = inst_mapped & ~inst_hit;
    assign o_iinvalid  = inst_mapped & inst_hit & ~inst_valid;
    assign o_imodified = inst_mapped & inst_hit & inst_valid & ~inst_dirty;

    // data port results
    assign o_dpaddr    = data_mapped ? {data_pfn, i_daddr[11:0]} : data_direct;
    assign o_duncached = data_mapped ? (data_hit & (data_cattr != 3'd3)) : data_seg_uc;
    assign o_drefill   = data_mapped & ~data_hit;
    assign o_dinvalid  = data_mapped & data_hit & ~data_valid;
    assign o_dmodified = data_mapped & data_hit & data_valid & ~data_dirty;

endmodule

`default_nettype wire

//--- bench/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
    input  wire logic        clk,
    input  wire logic        resetn,
    input  wire logic        i_req,
    input  wire logic        i_ack,
    input  wire logic [31:0] i_rdata,
    input  wire logic [31:0] i_ipaddr,
    input  wire logic        i_iuncached,
    input  wire logic        i_irefill,
    input  wire logic        i_iinvalid,
    input  wire logic        i_imodified,
    input  wire logic [31:0] i_dpaddr,
    input  wire logic        i_duncached,
    input  wire logic        i_drefill,
    input  wire logic        i_dinvalid,
    input  wire logic        i_dmodified
);

    int   err_count = 0;
    int   check_count = 0;
    int   test_count = 0;
    int   test_errs = 0;
    int   test_checks = 0;
    logic prev_ack = 1'b0;

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        check_count++;
        test_checks++;
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        check_count++;
        test_checks++;
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic fail_note(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        err_count++;
        test_errs++;
    endtask

    task automatic report_test(input string name);
        test_count++;
        $display("test %s: %0d checks, %0d errors, %s", name, test_checks, test_errs,
                 (test_errs == 0) ? "ok" : "FAILED");
        test_checks = 0;
        test_errs = 0;
    endtask

    task automatic print_summary();
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
    endtask

    // req and expectations change by nonblocking drive on this same edge,
    // so the values read here are the ones the DUT saw over the last cycle
    always @(negedge clk) begin
        if (!resetn) begin
            if (i_ack) begin
                fail_note("o_cmd_ack is high while reset is applied");
            end
        end else begin
            if (i_ack && !prev_ack && !i_req) begin
                fail_note("o_cmd_ack rose while req was low");
            end
            if (!i_ack && prev_ack && i_req) begin
                fail_note("o_cmd_ack dropped while req was still held high");
            end
            if (tb_top.rd_en && i_ack) begin
                compare_word("o_cmd_rdata", i_rdata, tb_top.exp_rdata);
            end
            if (tb_top.look_en) begin
                compare_bit("o_irefill", i_irefill, tb_top.exp_irf);
                compare_bit("o_iinvalid", i_iinvalid, tb_top.exp_iinv);
                compare_bit("o_imodified", i_imodified, tb_top.exp_imod);
                // paddr and uncached mean nothing on a refill
                if (!tb_top.exp_irf) begin
                    compare_word("o_ipaddr", i_ipaddr, tb_top.exp_ipaddr);
                    compare_bit("o_iuncached", i_iuncached, tb_top.exp_iuc);
                end
                compare_bit("o_drefill", i_drefill, tb_top.exp_drf);
                compare_bit("o_dinvalid", i_dinvalid, tb_top.exp_dinv);
                compare_bit("o_dmodified", i_dmodified, tb_top.exp_dmod);
                if (!tb_top.exp_drf) begin
                    compare_word("o_dpaddr", i_dpaddr, tb_top.exp_dpaddr);
                    compare_bit("o_duncached", i_duncached, tb_top.exp_duc);
                end
            end
        end
        prev_ack = i_ack;
    end

endmodule

`default_nettype wire

//--- bench/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmu_params.svh"

module tb_top import mmu_pkg::*; ();

    localparam int N          = `MMU_TLB_ENTRIES;
    localparam int CLK_PERIOD = 4;
    localparam int R_REPS     = 4;
    localparam int N_WR       = 24;
    localparam int N_RD       = 12;
    localparam int N_PR       = 16;
    localparam int N_UM       = 32;
    localparam int N_AS       = 8;
    localparam int N_LK       = 32;
    localparam int N_HS       = 12;
    localparam int N_CMDS     = 10 * R_REPS + 5 * N_WR + 5 * N_RD + 3 * N_PR + 2 + N_AS + N_HS;
    localparam int N_LOOK     = 2 * N_UM + N_AS * N_LK;
    localparam int WD_CYCLES  = N_CMDS * 10 + N_LOOK + 8 + 200;

    // writable bits, written out from the register layouts
    localparam logic [31:0] LO_MASK  = 32'h03FF_FFFF;
    localparam logic [31:0] HI_MASK  = 32'hFFFF_E0FF;
    localparam logic [31:0] IDX_MASK = 32'h8000_0000 | 32'(N - 1);
    localparam logic [31:0] CFG_MASK = 32'h0000_0001;

    logic        clk = 1'b0;
    logic        resetn;
    logic        cmd_req;
    cmd_op_e     cmd_op;
    reg_sel_e    cmd_sel;
    logic [31:0] cmd_wdata;
    logic        cmd_ack;
    logic [31:0] cmd_rdata;
    logic [31:0] iaddr;
    logic [31:0] daddr;
    logic [31:0] ipaddr;
    logic [31:0] dpaddr;
    logic        iuncached, irefill, iinvalid, imodified;
    logic        duncached, drefill, dinvalid, dmodified;

    // expectations read by the checker
    logic        look_en;
    logic        rd_en;
    logic [31:0] exp_rdata;
    logic [31:0] exp_ipaddr;
    logic [31:0] exp_dpaddr;
    logic        exp_iuc, exp_irf, exp_iinv, exp_imod;
    logic        exp_duc, exp_drf, exp_dinv, exp_dmod;

    // reference model state
    logic [31:0] m_index, m_lo0, m_lo1, m_hi, m_cfg;
    logic [31:0] m_thi [N];
    logic [31:0] m_tlo0 [N];
    logic [31:0] m_tlo1 [N];
    integer      seed;

    translation_unit UUT (
        .clk(clk), .resetn(resetn),
        .i_cmd_req(cmd_req), .i_cmd_op(cmd_op), .i_cmd_sel(cmd_sel),
        .i_cmd_wdata(cmd_wdata), .o_cmd_ack(cmd_ack), .o_cmd_rdata(cmd_rdata),
        .i_iaddr(iaddr), .o_ipaddr(ipaddr), .o_iuncached(iuncached),
        .o_irefill(irefill), .o_iinvalid(iinvalid), .o_imodified(imodified),
        .i_daddr(daddr), .o_dpaddr(dpaddr), .o_duncached(duncached),
        .o_drefill(drefill), .o_dinvalid(dinvalid), .o_dmodified(dmodified)
    );

    tb_checker chk (
        .clk(clk), .resetn(resetn), .i_req(cmd_req), .i_ack(cmd_ack), .i_rdata(cmd_rdata),
        .i_ipaddr(ipaddr), .i_iuncached(iuncached), .i_irefill(irefill),
        .i_iinvalid(iinvalid), .i_imodified(imodified),
        .i_dpaddr(dpaddr), .i_duncached(duncached), .i_drefill(drefill),
        .i_dinvalid(dinvalid), .i_dmodified(dmodified)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic entry_match(input int i, input logic [31:0] va);
        return (m_thi[i][31:13] == va[31:13]) &&
               ((m_thi[i][7:0] == m_hi[7:0]) || m_tlo0[i][0]);
    endfunction

    function automatic logic [31:0] model_read(input reg_sel_e sel);
        case (sel)
            SEL_INDEX:  return m_index;
            SEL_LO0:    return m_lo0;
            SEL_LO1:    return m_lo1;
            SEL_HI:     return m_hi;
            SEL_CONFIG: return m_cfg;
            default:    return 32'h0;
        endcase
    endfunction

    task automatic model_apply(input cmd_op_e op, input reg_sel_e sel, input logic [31:0] wd);
        logic g;
        int   k;
        int   hit;
        k = int'(m_index & 32'(N - 1));
        hit = -1;
        case (op)
            CMD_WREG: begin
                case (sel)
                    SEL_INDEX:  m_index = wd & IDX_MASK;
                    SEL_LO0:    m_lo0 = wd & LO_MASK;
                    SEL_LO1:    m_lo1 = wd & LO_MASK;
                    SEL_HI:     m_hi = wd & HI_MASK;
                    SEL_CONFIG: m_cfg = wd & CFG_MASK;
                    default: ;
                endcase
            end
            CMD_TLBWI: begin
                // one G per entry, kept in bit 0 of both halves
                g = m_lo0[0] & m_lo1[0];
                m_thi[k] = m_hi;
                m_tlo0[k] = {m_lo0[31:1], g};
                m_tlo1[k] = {m_lo1[31:1], g};
            end
            CMD_TLBR: begin
                m_hi = m_thi[k];
                m_lo0 = m_tlo0[k];
                m_lo1 = m_tlo1[k];
            end
            CMD_TLBP: begin
                for (int i = N - 1; i >= 0; i--) begin
                    if (entry_match(i, m_hi)) begin
                        hit = i;
                    end
                end
                m_index = (hit < 0) ? 32'h8000_0000 : 32'(hit);
            end
            default: ;
        endcase
    endtask

    task automatic predict(input logic [31:0] va, output logic [31:0] pa, output logic uc,
                           output logic rf, output logic inv, output logic md);
        logic [31:0] lo;
        int          hit;
        hit = -1;
        lo = 32'h0;
        if (va[31:30] == 2'b10) begin
            pa = {3'b000, va[28:0]};
            uc = va[29] | m_cfg[0];
            rf = 1'b0;
            inv = 1'b0;
            md = 1'b0;
        end else begin
            for (int i = N - 1; i >= 0; i--) begin
                if (entry_match(i, va)) begin
                    hit = i;
                end
            end
            if (hit >= 0) begin
                lo = va[12] ? m_tlo1[hit] : m_tlo0[hit];
            end
            pa = {lo[25:6], va[11:0]};
            uc = (hit >= 0) && (lo[5:3] != 3'd3);
            rf = (hit < 0);
            inv = (hit >= 0) && !lo[1];
            md = (hit >= 0) && lo[1] && !lo[2];
        end
    endtask

    // one four-phase command, with a random hold of req after ack
    task automatic host_cmd(input cmd_op_e op, input reg_sel_e sel, input logic [31:0] wd);
        int waited;
        int hold;
        hold = $unsigned($random(seed)) % 5;
        @(negedge clk);
        cmd_req <= 1'b1;
        cmd_op <= op;
        cmd_sel <= sel;
        cmd_wdata <= wd;
        // lookup expectations go stale once the command changes the state
        look_en <= 1'b0;
        rd_en <= (op == CMD_RREG);
        exp_rdata <= model_read(sel);
        waited = 0;
        @(negedge clk);
        while (!cmd_ack && waited < 8) begin
            waited++;
            @(negedge clk);
        end
        if (!cmd_ack) begin
            chk.fail_note("o_cmd_ack never rose after req was raised");
        end
        repeat (hold) @(negedge clk);
        cmd_req <= 1'b0;
        rd_en <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (cmd_ack && waited < 8) begin
            waited++;
            @(negedge clk);
        end
        if (cmd_ack) begin
            chk.fail_note("o_cmd_ack did not clear after req was dropped");
        end
        model_apply(op, sel, wd);
    endtask

    task automatic lookup(input logic [31:0] ia, input logic [31:0] da);
        logic [31:0] pa;
        logic        uc, rf, inv, md;
        @(negedge clk);
        iaddr <= ia;
        daddr <= da;
        predict(ia, pa, uc, rf, inv, md);
        exp_ipaddr <= pa;
        exp_iuc <= uc;
        exp_irf <= rf;
        exp_iinv <= inv;
        exp_imod <= md;
        predict(da, pa, uc, rf, inv, md);
        exp_dpaddr <= pa;
        exp_duc <= uc;
        exp_drf <= rf;
        exp_dinv <= inv;
        exp_dmod <= md;
        look_en <= 1'b1;
    endtask

    task automatic close_test(input string name);
        @(negedge clk);
        look_en <= 1'b0;
        @(negedge clk);
        chk.report_test(name);
    endtask

    // random address outside kseg0/kseg1
    function automatic logic [31:0] rand_mapped();
        logic [31:0] a;
        a = $random(seed);
        if (a[31:30] == 2'b10) begin
            a[31] = 1'b0;
        end
        return a;
    endfunction

    // about half the lookups land on the vpn2 of some table entry
    function automatic logic [31:0] pick_mapped();
        logic [31:0] a;
        int          j;
        a = rand_mapped();
        j = $unsigned($random(seed)) % N;
        if (a[0]) begin
            a[31:13] = m_thi[j][31:13];
        end
        return a;
    endfunction

    function automatic logic [31:0] pick_unmapped();
        logic [31:0] a;
        a = $random(seed);
        a[31:30] = 2'b10;
        return a;
    endfunction

    function automatic logic [31:0] probe_word();
        logic [31:0] w;
        int          j;
        w = $random(seed);
        j = $unsigned($random(seed)) % N;
        if (w[1:0] != 2'b00) begin
            w[31:13] = m_thi[j][31:13];
            // own asid, or a foreign one that only a G entry matches
            if (w[2]) begin
                w[7:0] = m_thi[j][7:0];
            end
        end
        return w;
    endfunction

    initial begin
        #(WD_CYCLES * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d cycles", WD_CYCLES);
        $display("Regression failed");
        $finish;
    end

    initial begin
        int j;
        seed = 32'h6e2a;
        resetn = 1'b0;
        cmd_req = 1'b0;
        cmd_op = CMD_WREG;
        cmd_sel = SEL_INDEX;
        cmd_wdata = 32'h0;
        iaddr = 32'h0;
        daddr = 32'h0;
        look_en = 1'b0;
        rd_en = 1'b0;
        exp_rdata = 32'h0;
        {m_index, m_lo0, m_lo1, m_hi, m_cfg} = '0;
        for (int i = 0; i < N; i++) begin
            m_thi[i] = 32'h0;
            m_tlo0[i] = 32'h0;
            m_tlo1[i] = 32'h0;
        end
        repeat (8) @(negedge clk);
        resetn <= 1'b1;

        for (int r = 0; r < R_REPS; r++) begin
            for (int s = 0; s < 5; s++) begin
                host_cmd(CMD_WREG, reg_sel_e'(s), $random(seed));
                host_cmd(CMD_RREG, reg_sel_e'(s), $random(seed));
            end
        end
        close_test("register write/read");

        for (int w = 0; w < N_WR; w++) begin
            host_cmd(CMD_WREG, SEL_HI, rand_mapped());
            host_cmd(CMD_WREG, SEL_LO0, $random(seed));
            host_cmd(CMD_WREG, SEL_LO1, $random(seed));
            host_cmd(CMD_WREG, SEL_INDEX, $random(seed));
            host_cmd(CMD_TLBWI, SEL_INDEX, 32'h0);
        end
        for (int r = 0; r < N_RD; r++) begin
            host_cmd(CMD_WREG, SEL_INDEX, $random(seed));
            host_cmd(CMD_TLBR, SEL_INDEX, 32'h0);
            host_cmd(CMD_RREG, SEL_HI, 32'h0);
            host_cmd(CMD_RREG, SEL_LO0, 32'h0);
            host_cmd(CMD_RREG, SEL_LO1, 32'h0);
        end
        close_test("tlbwi/tlbr");

        for (int p = 0; p < N_PR; p++) begin
            host_cmd(CMD_WREG, SEL_HI, probe_word());
            host_cmd(CMD_TLBP, SEL_INDEX, 32'h0);
            host_cmd(CMD_RREG, SEL_INDEX, 32'h0);
        end
        close_test("tlbp");

        for (int c = 0; c < 2; c++) begin
            host_cmd(CMD_WREG, SEL_CONFIG, 32'(c));
            for (int u = 0; u < N_UM; u++) begin
                lookup(pick_unmapped(), pick_unmapped());
            end
        end
        close_test("unmapped");

        for (int a = 0; a < N_AS; a++) begin
            j = $unsigned($random(seed)) % N;
            host_cmd(CMD_WREG, SEL_HI, (a % 2 == 0) ? m_thi[j] : $random(seed));
            for (int k = 0; k < N_LK; k++) begin
                lookup(pick_mapped(), pick_mapped());
            end
        end
        close_test("mapped lookup");

        for (int h = 0; h < N_HS; h++) begin
            host_cmd(CMD_RREG, reg_sel_e'($unsigned($random(seed)) % 5), 32'h0);
        end
        close_test("handshake");

        chk.print_summary();
        if (chk.err_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+src
src/mmu_pkg.sv
src/seg_mapper.sv
src/tlb_match.sv
src/tlb_array.sv
src/tlb_regs.sv
src/translation_unit.sv
bench/tb_checker.sv
bench/tb_top.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" \
    && verilator --binary --timing --top-module tb_top -f tb.f -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "Regression passed" \
    && echo "simulation ok" \
    || { echo "simulation did not pass"; exit 1; }
